/* flist.f */
rtl/cacheGeomPkg.sv
rtl/wbBusPkg.sv
rtl/cacheTagStore.sv
rtl/cacheDataStore.sv
rtl/readCache.sv
rtl/wbArbiter.sv
rtl/cacheSubsystem.sv
verification/wbMemModel.sv
verification/tbCacheSubsystem.sv

/* Makefile */
TOP := tbCacheSubsystem
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP) -o simv
	./obj_dir/simv | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* verification/tbCacheSubsystem.sv */
`default_nettype none

module tbCacheSubsystem;
  timeunit 1ns;
  timeprecision 100ps;
  import cacheGeomPkg::*;
  import wbBusPkg::*;

  localparam int NUM_TESTS = 6;
  localparam int RAND_REQS = 200;

  logic              clk = 1'b0;
  logic              rst_n = 1'b0;
  cacheReq_t         instReq;
  cacheReq_t         dataReq;
  logic              instRdy;
  logic              dataRdy;
  cacheRsp_t         instRsp;
  cacheRsp_t         dataRsp;
  wbM2s_t            wbM2s;
  wbS2m_t            wbS2m;
  string             testName = "reset state";
  int                errCnt = 0;
  int                errAtStart = 0;
  int                passCnt = 0;
  int                failCnt = 0;
  int                seed = 80;
  // reset-state window and hit-only window
  logic              idleCheck = 1'b1;
  logic              hitOnly = 1'b0;
  // expected words of accepted requests, oldest first
  logic [XLEN-1:0]   instQ[$];
  logic [XLEN-1:0]   dataQ[$];
  logic [XLEN-1:0]   instHead = '0;
  logic [XLEN-1:0]   dataHead = '0;
  int                instPend = 0;
  int                dataPend = 0;
  // last accepted address per port, the one a refill serves
  logic [ADDR_W-1:0] instLast = '0;
  logic [ADDR_W-1:0] dataLast = '0;
  // beats of the open bus cycle and its line
  logic [2:0]        beats = '0;
  logic [26:0]       lineBase = '0;
  logic [WB_AW-1:0]  expAdr;
  logic [ADDR_W-1:0] instAddrs[RAND_REQS];
  logic [ADDR_W-1:0] dataAddrs[RAND_REQS];

  cacheSubsystem UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .instReq_i (instReq),
    .dataReq_i (dataReq),
    .instRdy_o (instRdy),
    .dataRdy_o (dataRdy),
    .instRsp_o (instRsp),
    .dataRsp_o (dataRsp),
    .wbM2s_o   (wbM2s),
    .wbS2m_i   (wbS2m)
  );

  wbMemModel memory (
    .clk   (clk),
    .rst_n (rst_n),
    .bus_i (wbM2s),
    .bus_o (wbS2m)
  );

  // 8 ns period
  initial begin
    forever #4 clk = ~clk;
  end

  // word at the request address, low three bits dropped
  function automatic logic [XLEN-1:0] expectedWord(input logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0] a;
    a = {addr[ADDR_W-1:3], 3'b000};
    return {~a, a};
  endfunction

  task automatic showMismatch(input string what, input logic [63:0] exp, input logic [63:0] act);
    errCnt++;
    $display("CHECK FAILED %s: %s expected %h, actual %h", testName, what, exp, act);
  endtask

  task automatic flagProblem(input string what);
    errCnt++;
    $display("ERROR %s: %s at %0t ns", testName, what, $time);
  endtask

  // scoreboard, pre-edge values, pop then push
  always @(posedge clk) begin
    if (!rst_n) begin
      instQ.delete();
      dataQ.delete();
    end else begin
      if (instRsp.valid && instQ.size() > 0) void'(instQ.pop_front());
      if (dataRsp.valid && dataQ.size() > 0) void'(dataQ.pop_front());
      if (instReq.valid && instRdy) begin
        instQ.push_back(expectedWord(instReq.addr.raw));
        instLast = instReq.addr.raw;
      end
      if (dataReq.valid && dataRdy) begin
        dataQ.push_back(expectedWord(dataReq.addr.raw));
        dataLast = dataReq.addr.raw;
      end
    end
    instPend = instQ.size();
    dataPend = dataQ.size();
    instHead = (instPend > 0) ? instQ[0] : '0;
    dataHead = (dataPend > 0) ? dataQ[0] : '0;
  end

  // beat tracker for the bus cycle checks
  always @(posedge clk) begin
    if (!wbM2s.cyc) begin
      beats <= '0;
    end else if (wbS2m.ack) begin
      beats <= beats + 3'd1;
      if (beats == 3'd0) lineBase <= wbM2s.adr[31:5];
    end
  end

  // later beats step by 8 within the line of the first beat
  assign expAdr = {lineBase, beats[1:0], 3'b000};

  idleOutputs: assert property (@(negedge clk)
    idleCheck |-> !instRsp.valid && !dataRsp.valid && !wbM2s.cyc && instRdy && dataRdy)
    else flagProblem("outputs not in their reset state");
  instOrphan: assert property (@(negedge clk) disable iff (!rst_n)
    instRsp.valid |-> instPend > 0)
    else flagProblem("inst response without an open request");
  dataOrphan: assert property (@(negedge clk) disable iff (!rst_n)
    dataRsp.valid |-> dataPend > 0)
    else flagProblem("data response without an open request");
  instWord: assert property (@(negedge clk) disable iff (!rst_n)
    instRsp.valid && instPend > 0 |-> instRsp.data == instHead)
    else showMismatch("inst response", instHead, instRsp.data);
  dataWord: assert property (@(negedge clk) disable iff (!rst_n)
    dataRsp.valid && dataPend > 0 |-> dataRsp.data == dataHead)
    else showMismatch("data response", dataHead, dataRsp.data);
  instHitTime: assert property (@(negedge clk) disable iff (!rst_n)
    hitOnly && instReq.valid && instRdy |=> instRsp.valid)
    else flagProblem("inst hit did not respond one cycle after acceptance");
  dataHitTime: assert property (@(negedge clk) disable iff (!rst_n)
    hitOnly && dataReq.valid && dataRdy |=> dataRsp.valid)
    else flagProblem("data hit did not respond one cycle after acceptance");
  hitQuiet: assert property (@(negedge clk) disable iff (!rst_n)
    hitOnly |-> !wbM2s.cyc)
    else flagProblem("bus cycle started while only hits were expected");
  beatShape: assert property (@(negedge clk) disable iff (!rst_n)
    wbM2s.cyc |-> wbM2s.stb && !wbM2s.we && wbM2s.dat == '0)
    else flagProblem("strobe low, write or write data inside a refill cycle");
  firstBeat: assert property (@(negedge clk) disable iff (!rst_n)
    wbM2s.cyc && wbS2m.ack && beats == 3'd0 |->
      (wbM2s.adr == {instLast[31:5], 5'b0}) || (wbM2s.adr == {dataLast[31:5], 5'b0}))
    else flagProblem("first beat not at the aligned line of a missed request");
  beatAddr: assert property (@(negedge clk) disable iff (!rst_n)
    wbM2s.cyc && wbS2m.ack && beats != 3'd0 |-> wbM2s.adr == expAdr)
    else showMismatch("beat address", expAdr, wbM2s.adr);
  beatLimit: assert property (@(negedge clk) disable iff (!rst_n)
    wbM2s.cyc && wbS2m.ack |-> beats < 3'd4)
    else flagProblem("more than four beats in one bus cycle");
  cycleEnd: assert property (@(negedge clk) disable iff (!rst_n)
    $fell(wbM2s.cyc) |-> beats == 3'd4)
    else flagProblem($sformatf("bus cycle closed after %0d beats", beats));

  // hold valid until the edge after a ready cycle
  task automatic sendReq(input bit side, input logic [ADDR_W-1:0] addr);
    if (side) begin
      dataReq.valid = 1'b1;
      dataReq.addr.raw = addr;
    end else begin
      instReq.valid = 1'b1;
      instReq.addr.raw = addr;
    end
    do begin
      @(negedge clk);
    end while (!(side ? dataRdy : instRdy));
    @(posedge clk);
    #1;
    if (side) dataReq.valid = 1'b0;
    else instReq.valid = 1'b0;
  endtask

  // until every accepted request has its response
  task automatic drainAll();
    while (instPend != 0 || dataPend != 0) begin
      @(posedge clk);
      #1;
    end
    // last refill cycle closes
    repeat (3) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic startTest(input string name);
    testName = name;
    errAtStart = errCnt;
  endtask

  task automatic endTest();
    if (errCnt == errAtStart) begin
      passCnt++;
      $display("test %s: passed", testName);
    end else begin
      failCnt++;
      $display("test %s: failed with %0d errors", testName, errCnt - errAtStart);
    end
  endtask

  initial begin
    instReq = '0;
    dataReq = '0;
    startTest("reset state");
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (3) begin
      @(posedge clk);
      #1;
    end
    idleCheck = 1'b0;
    endTest();

    startTest("cold miss");
    sendReq(1'b0, 32'h0000_0108);
    drainAll();
    endTest();

    // back-to-back words of the line just filled
    startTest("hit");
    hitOnly = 1'b1;
    sendReq(1'b0, 32'h0000_0100);
    sendReq(1'b0, 32'h0000_011F);
    sendReq(1'b0, 32'h0000_0115);
    sendReq(1'b0, 32'h0000_010B);
    drainAll();
    hitOnly = 1'b0;
    endTest();

    // index 2 with tags 0 and 1
    startTest("two ways");
    sendReq(1'b1, 32'h0000_0040);
    sendReq(1'b1, 32'h0000_0848);
    drainAll();
    hitOnly = 1'b1;
    sendReq(1'b1, 32'h0000_0058);
    sendReq(1'b1, 32'h0000_0840);
    sendReq(1'b1, 32'h0000_0047);
    drainAll();
    hitOnly = 1'b0;
    endTest();

    startTest("arbitration");
    fork
      sendReq(1'b0, 32'h0000_1010);
      sendReq(1'b1, 32'h0000_2028);
    join
    drainAll();
    endTest();

    // 8 lines of one range, shared by both ports
    startTest("random stream");
    for (int i = 0; i < RAND_REQS; i++) begin
      instAddrs[i] = 32'h0000_4000 + ($random(seed) & 32'h0000_00FF);
      dataAddrs[i] = 32'h0000_4000 + ($random(seed) & 32'h0000_00FF);
    end
    fork
      begin
        for (int i = 0; i < RAND_REQS; i++) sendReq(1'b0, instAddrs[i]);
      end
      begin
        for (int j = 0; j < RAND_REQS; j++) sendReq(1'b1, dataAddrs[j]);
      end
    join
    drainAll();
    endTest();

    $display("summary: %0d tests, %0d passed, %0d failed, %0d check errors",
             NUM_TESTS, passCnt, failCnt, errCnt);
    if (failCnt == 0 && errCnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // 2000 ns budget per test
  initial begin
    #(NUM_TESTS * 2000);
    $display("watchdog: run did not finish within %0d ns", NUM_TESTS * 2000);
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/wbMemModel.sv */
`default_nettype none

module wbMemModel (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire wbBusPkg::wbM2s_t bus_i,
  output wbBusPkg::wbS2m_t      bus_o
);
  timeunit 1ns;
  timeprecision 100ps;
  import wbBusPkg::*;

  // wait state draws
  int         seed = 80;
  // beat seen, wait states still running
  logic       busy;
  logic [1:0] waitCnt;

  // word at byte address A holds A low and ~A high
  function automatic logic [WB_DW-1:0] memWord(input logic [WB_AW-1:0] adr);
    return {~adr, adr};
  endfunction

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      waitCnt <= '0;
      bus_o <= '0;
    end else begin
      // ack is a one-cycle pulse
      bus_o.ack <= 1'b0;
      if (!(bus_i.cyc && bus_i.stb)) begin
        busy <= 1'b0;
      end else if (!busy && !bus_o.ack) begin
        // fresh beat, 0 to 3 wait states
        busy <= 1'b1;
        waitCnt <= 2'($random(seed));
      end else if (busy && waitCnt != 2'd0) begin
        waitCnt <= waitCnt - 2'd1;
      end else if (busy) begin
        // end the beat with the word at adr
        busy <= 1'b0;
        bus_o.ack <= 1'b1;
        bus_o.dat <= memWord(bus_i.adr);
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/cacheSubsystem.sv */
`default_nettype none

module cacheSubsystem (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire cacheGeomPkg::cacheReq_t instReq_i,
  input  wire cacheGeomPkg::cacheReq_t dataReq_i,
  output logic                         instRdy_o,
  output logic                         dataRdy_o,
  output cacheGeomPkg::cacheRsp_t      instRsp_o,
  output cacheGeomPkg::cacheRsp_t      dataRsp_o,
  output wbBusPkg::wbM2s_t             wbM2s_o,
  input  wire wbBusPkg::wbS2m_t        wbS2m_i
);
  import wbBusPkg::*;

  // refill masters toward the arbiter
  wbM2s_t instM2s;
  wbM2s_t dataM2s;
  // gated slave side back to each cache
  wbS2m_t instS2m;
  wbS2m_t dataS2m;

  // instruction side, master 0
  readCache instCache (
    .clk     (clk),
    .rst_n   (rst_n),
    .req_i   (instReq_i),
    .ready_o (instRdy_o),
    .rsp_o   (instRsp_o),
    .wb_o    (instM2s),
    .wb_i    (instS2m)
  );

  // data side, master 1
  readCache dataCache (
    .clk     (clk),
    .rst_n   (rst_n),
    .req_i   (dataReq_i),
    .ready_o (dataRdy_o),
    .rsp_o   (dataRsp_o),
    .wb_o    (dataM2s),
    .wb_i    (dataS2m)
  );

  wbArbiter arbiter (
    .clk   (clk),
    .rst_n (rst_n),
    .m0_i  (instM2s),
    .m1_i  (dataM2s),
    .m0_o  (instS2m),
    .m1_o  (dataS2m),
    .bus_o (wbM2s_o),
    .bus_i (wbS2m_i)
  );

endmodule

`default_nettype wire

/* rtl/wbArbiter.sv */
`default_nettype none

module wbArbiter (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire wbBusPkg::wbM2s_t m0_i,
  input  wire wbBusPkg::wbM2s_t m1_i,
  output wbBusPkg::wbS2m_t      m0_o,
  output wbBusPkg::wbS2m_t      m1_o,
  output wbBusPkg::wbM2s_t      bus_o,
  input  wire wbBusPkg::wbS2m_t bus_i
);

  // a master owns the bus
  logic grantValid;
  // owner while busy, last winner while idle
  logic lastWin;
  // idle-time choice
  logic pick;
  // master routed to the bus this cycle
  logic sel;

  // round robin, last winner loses a tie
  always_comb begin
    if (m0_i.cyc && m1_i.cyc) begin
      pick = ~lastWin;
    end else begin
      pick = m1_i.cyc;
    end
  end

  // grant held while the owner keeps cyc up
  assign sel = grantValid ? lastWin : pick;

  always_comb begin
    if (sel) begin
      bus_o = m1_i;
    end else begin
      bus_o = m0_i;
    end
  end

  // read data shared, ack only to the routed master
  always_comb begin
    m0_o.dat = bus_i.dat;
    m1_o.dat = bus_i.dat;
    m0_o.ack = bus_i.ack && !sel;
    m1_o.ack = bus_i.ack && sel;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grantValid <= 1'b0;
      // master 0 wins the first tie
      lastWin <= 1'b1;
    end else if (!grantValid) begin
      if (m0_i.cyc || m1_i.cyc) begin
        grantValid <= 1'b1;
        lastWin <= pick;
      end
    end else if (!bus_o.cyc) begin
      // owner closed its cycle, decide again next cycle
      grantValid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* rtl/readCache.sv */
`default_nettype none

module readCache (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire cacheGeomPkg::cacheReq_t req_i,
  output logic                         ready_o,
  output cacheGeomPkg::cacheRsp_t      rsp_o,
  output wbBusPkg::wbM2s_t             wb_o,
  input  wire wbBusPkg::wbS2m_t        wb_i
);
  import cacheGeomPkg::*;

  typedef enum logic [1:0] {
    stIdle,
    stCompare,
    stRefill,
    stRespond
  } cacheState_t;

  cacheState_t                     state;
  cacheState_t                     stateNext;
  cacheAddr_u                      reqAddr;
  cacheAddr_u                      beatAddr;
  logic [WAYS-1:0]                 hitWay;
  logic                            hit;
  logic                            victimWay;
  logic                            accept;
  logic                            beatAck;
  logic                            lastBeat;
  logic                            fillEn;
  logic [WSEL_W-1:0]               beatCnt;
  logic [IDX_W-1:0]                rdIdx;
  logic [LINE_WORDS-1:0][XLEN-1:0] refillBuf;
  logic [XLEN-1:0]                 storeWord;

  assign hit = |hitWay;
  // idle always takes a request, compare only behind a hit
  assign ready_o = (state == stIdle) || ((state == stCompare) && hit);
  assign accept = req_i.valid && ready_o;
  // incoming set goes straight to the data store read
  assign rdIdx = accept ? req_i.addr.f.idx : reqAddr.f.idx;
  assign beatAck = (state == stRefill) && wb_i.ack;
  assign lastBeat = beatAck && (&beatCnt);
  assign fillEn = (state == stRespond);

  always_comb begin
    stateNext = state;
    unique case (state)
      stIdle: begin
        if (accept) begin
          stateNext = stCompare;
        end
      end
      stCompare: begin
        // a hit with a new request stays here, pipelined
        if (!hit) begin
          stateNext = stRefill;
        end else if (!req_i.valid) begin
          stateNext = stIdle;
        end
      end
      stRefill: begin
        if (lastBeat) begin
          stateNext = stRespond;
        end
      end
      stRespond: begin
        stateNext = stIdle;
      end
      default: begin
        stateNext = stIdle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= stIdle;
      beatCnt <= '0;
    end else begin
      state <= stateNext;
      // wraps back to zero after the fourth beat
      if (beatAck) begin
        beatCnt <= beatCnt + 1'b1;
      end
    end
  end

  // request address and refill words
  always_ff @(posedge clk) begin
    if (accept) begin
      reqAddr <= req_i.addr;
    end
    if (beatAck) begin
      refillBuf[beatCnt] <= wb_i.dat;
    end
  end

  // line-aligned base plus beat number
  always_comb begin
    beatAddr = reqAddr;
    beatAddr.f.wordSel = beatCnt;
    beatAddr.f.byteOff = '0;
  end

  // refill master, cyc and stb drop when the state leaves refill
  always_comb begin
    wb_o.cyc = (state == stRefill);
    wb_o.stb = (state == stRefill);
    wb_o.we = 1'b0;
    wb_o.adr = beatAddr.raw;
    wb_o.dat = '0;
  end

  // hit word from the store, miss word from the refill buffer
  always_comb begin
    rsp_o.valid = ((state == stCompare) && hit) || fillEn;
    rsp_o.data = fillEn ? refillBuf[reqAddr.f.wordSel] : storeWord;
  end

  cacheTagStore tagStore (
    .clk          (clk),
    .rst_n        (rst_n),
    .lookupAddr_i (reqAddr),
    .fillEn_i     (fillEn),
    .hitWay_o     (hitWay),
    .victimWay_o  (victimWay)
  );

  cacheDataStore dataStore (
    .clk       (clk),
    .rdIdx_i   (rdIdx),
    .wrEn_i    (fillEn),
    .wrWay_i   (victimWay),
    .wrIdx_i   (reqAddr.f.idx),
    .wrLine_i  (refillBuf),
    .hitWay_i  (hitWay),
    .wordSel_i (reqAddr.f.wordSel),
    .word_o    (storeWord)
  );

endmodule

`default_nettype wire

/* rtl/cacheDataStore.sv */
`default_nettype none

module cacheDataStore (
  input  wire logic                                clk,
  input  wire logic [cacheGeomPkg::IDX_W-1:0]      rdIdx_i,
  input  wire logic                                wrEn_i,
  input  wire logic                                wrWay_i,
  input  wire logic [cacheGeomPkg::IDX_W-1:0]      wrIdx_i,
  input  wire logic [cacheGeomPkg::LINE_W-1:0]     wrLine_i,
  input  wire logic [cacheGeomPkg::WAYS-1:0]       hitWay_i,
  input  wire logic [cacheGeomPkg::WSEL_W-1:0]     wordSel_i,
  output logic [cacheGeomPkg::XLEN-1:0]            word_o
);
  import cacheGeomPkg::*;

  // registered lines of both ways, read in the acceptance cycle
  logic [WAYS-1:0][LINE_WORDS-1:0][XLEN-1:0] rdLine;

  for (genvar w = 0; w < WAYS; w++) begin : gWay
    logic [LINE_W-1:0] lineMem [SETS];

    // whole line written at the end of a refill
    always_ff @(posedge clk) begin
      if (wrEn_i && (wrWay_i == 1'(w))) begin
        lineMem[wrIdx_i] <= wrLine_i;
      end
    end

    // read every cycle, the controller steers the index
    always_ff @(posedge clk) begin
      rdLine[w] <= lineMem[rdIdx_i];
    end
  end

  // word select then one-hot way select
  always_comb begin
    word_o = '0;
    for (int w = 0; w < WAYS; w++) begin
      word_o = word_o | ({XLEN{hitWay_i[w]}} & rdLine[w][wordSel_i]);
    end
  end

endmodule

`default_nettype wire

/* rtl/cacheTagStore.sv */
`default_nettype none

module cacheTagStore (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire cacheGeomPkg::cacheAddr_u lookupAddr_i,
  input  wire logic                     fillEn_i,
  output logic [cacheGeomPkg::WAYS-1:0] hitWay_o,
  output logic                          victimWay_o
);
  import cacheGeomPkg::*;

  // valid bit of the looked-up set, one per way
  logic [WAYS-1:0] wayValid;
  // replacement bits, stepped once per fill
  logic [7:0]      lfsr;

  for (genvar w = 0; w < WAYS; w++) begin : gWay
    logic [TAG_W-1:0] tagMem [SETS];
    logic [SETS-1:0]  validMem;
    logic             wrThis;

    // this way takes the fill only when it is the victim
    assign wrThis = fillEn_i && (victimWay_o == 1'(w));

    always_ff @(posedge clk) begin
      if (wrThis) begin
        tagMem[lookupAddr_i.f.idx] <= lookupAddr_i.f.tag;
      end
    end

    // all lines invalid out of reset
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        validMem <= '0;
      end else if (wrThis) begin
        validMem[lookupAddr_i.f.idx] <= 1'b1;
      end
    end

    assign wayValid[w] = validMem[lookupAddr_i.f.idx];
    // combinational compare against the latched request
    assign hitWay_o[w] = wayValid[w] &&
                         (tagMem[lookupAddr_i.f.idx] == lookupAddr_i.f.tag);
  end

  // first invalid way wins, else pseudo random
  always_comb begin
    victimWay_o = lfsr[0];
    if (!wayValid[1]) begin
      victimWay_o = 1'b1;
    end
    if (!wayValid[0]) begin
      victimWay_o = 1'b0;
    end
  end

  // x^8 + x^6 + x^5 + x^4 + 1, never reaches zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsr <= 8'hA5;
    end else if (fillEn_i) begin
      lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
    end
  end

endmodule

`default_nettype wire

/* rtl/wbBusPkg.sv */
`default_nettype none

package wbBusPkg;

  // memory side Wishbone classic widths
  localparam int WB_DW = 64;
  localparam int WB_AW = 32;

  // master outputs
  typedef struct packed {
    // held for the whole multi-beat cycle
    logic             cyc;
    // one beat pending
    logic             stb;
    // always low here, refills only read
    logic             we;
    logic [WB_AW-1:0] adr;
    // write data, unused by a read-only master
    logic [WB_DW-1:0] dat;
  } wbM2s_t;

  // slave outputs
  typedef struct packed {
    // ends the current beat
    logic             ack;
    // read data, valid with ack
    logic [WB_DW-1:0] dat;
  } wbS2m_t;

endpackage

`default_nettype wire

/* rtl/cacheGeomPkg.sv */
`default_nettype none

package cacheGeomPkg;

  // core side widths
  localparam int ADDR_W = 32;
  localparam int XLEN = 64;

  // two ways of 64 sets, 32-byte lines of four words
  localparam int WAYS = 2;
  localparam int SETS = 64;
  localparam int LINE_WORDS = 4;

  // address split as tag | index | offset
  localparam int TAG_W = 21;
  localparam int IDX_W = 6;
  localparam int OFF_W = 5;

  // offset split again into word select and byte in word
  localparam int WSEL_W = $clog2(LINE_WORDS);
  localparam int BYTE_W = OFF_W - WSEL_W;
  // one full line as stored in a way
  localparam int LINE_W = LINE_WORDS * XLEN;

  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [IDX_W-1:0]  idx;
    logic [WSEL_W-1:0] wordSel;
    logic [BYTE_W-1:0] byteOff;
  } cacheAddrFields_t;

  // one address word, flat for the bus or split for the stores
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    cacheAddrFields_t  f;
  } cacheAddr_u;

  // core to cache, one request per accepted cycle
  typedef struct packed {
    logic       valid;
    cacheAddr_u addr;
  } cacheReq_t;

  // cache to core, valid for exactly one cycle
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] data;
  } cacheRsp_t;

endpackage

`default_nettype wire
